//--- common/core_consts.svh
// Widths are fixed at twelve bits and opcode bit 4 marks the immediate form
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_DATA_W     12
`define CORE_ADDR_W     12
`define CORE_INSTR_W    24
`define CORE_REG_N      16
`define CORE_REG_IDX_W  4
`define CORE_LINK_REG   4'd15
`define CORE_OPC_W      5
`define CORE_COND_W     3
`define CORE_FLAGS_W    4

// Base opcodes with the immediate bit clear
`define OPC_MOV  5'h00
`define OPC_ADD  5'h01
`define OPC_SUB  5'h02
`define OPC_CMP  5'h03
`define OPC_AND  5'h04
`define OPC_OR   5'h05
`define OPC_XOR  5'h06
`define OPC_NOT  5'h07
`define OPC_SL   5'h08
`define OPC_SR   5'h09
`define OPC_BR   5'h0A
`define OPC_BRL  5'h0B
`define OPC_ST   5'h0C
`define OPC_HLT  5'h0D

// Opcode bit that selects the immediate operand
`define OPC_IMM_BIT  4

// Condition bit that turns SR into an arithmetic shift
`define SR_ARITH_BIT 0

`define BCC_AL  3'd0
`define BCC_EQ  3'd1
`define BCC_NE  3'd2
`define BCC_LT  3'd3
`define BCC_GT  3'd4
`define BCC_LE  3'd5
`define BCC_GE  3'd6

`define FLAG_Z  0
`define FLAG_C  1
`define FLAG_N  2
`define FLAG_V  3

`endif

//--- common/core_pkg.sv
// Type widths follow core_consts.svh and the structs hold no behavior of their own
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef logic [`CORE_DATA_W-1:0]    data_t;
    typedef logic [`CORE_ADDR_W-1:0]    addr_t;
    typedef logic [`CORE_INSTR_W-1:0]   instr_t;
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CORE_FLAGS_W-1:0]   flags_t;
    typedef logic [`CORE_OPC_W-1:0]     opcode_t;
    typedef logic [`CORE_COND_W-1:0]    cond_t;

    // Decode pipeline register
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        cond_t    cond;
        reg_idx_t rd;
        logic     imm_en;
        data_t    imm;
        data_t    rs_data;
        data_t    rd_data;
        addr_t    pc;
    } decoded_t;

    // Execute output register
    typedef struct packed {
        logic     wb_valid;
        reg_idx_t wb_reg;
        data_t    wb_data;
        flags_t   flags;
        logic     branch_taken;
        addr_t    branch_target;
        logic     store_valid;
        data_t    store_addr;
        data_t    store_data;
    } exec_result_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
// Reads are combinational and a read of the register being written returns the old value
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t rd_addr_a,
    input  core_pkg::reg_idx_t rd_addr_b,
    output core_pkg::data_t    rd_data_a,
    output core_pkg::data_t    rd_data_b,
    input  logic               wr_en,
    input  core_pkg::reg_idx_t wr_addr,
    input  core_pkg::data_t    wr_data
);

    core_pkg::data_t regs [`CORE_REG_N];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

//--- src/issue_decode.sv
// A taken branch reloads the PC ahead of any issue in the same cycle and strobes are dropped while halted
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module issue_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  core_pkg::instr_t   instr,
    input  logic               halted,
    input  logic               branch_taken,
    input  core_pkg::addr_t    branch_target,
    output core_pkg::reg_idx_t rs_idx,
    output core_pkg::reg_idx_t rd_idx,
    input  core_pkg::data_t    rs_data,
    input  core_pkg::data_t    rd_data,
    output core_pkg::decoded_t dec,
    output core_pkg::addr_t    pc
);

    logic              accept;
    core_pkg::opcode_t opcode;
    core_pkg::cond_t   cond;
    core_pkg::data_t   imm;

    assign accept = instr_valid && !halted;

    // Field split of the instruction word
    assign opcode = instr[23:19];
    assign cond   = instr[18:16];
    assign rd_idx = instr[15:12];
    assign rs_idx = instr[11:8];

    // Twelve-bit immediate already fills the data word
    assign imm = instr[11:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (accept) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec.valid <= accept;
            if (accept) begin
                dec.opcode  <= opcode;
                dec.cond    <= cond;
                dec.rd      <= rd_idx;
                dec.imm_en  <= opcode[`OPC_IMM_BIT];
                dec.imm     <= imm;
                dec.rs_data <= rs_data;
                dec.rd_data <= rd_data;
                // PC of this instruction, before the increment
                dec.pc      <= pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- execute/alu.sv
// Shift amount uses only the low four bits of b and carry means no borrow on subtract
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module alu (
    input  core_pkg::opcode_t opcode,
    input  logic              arith_shift,
    input  core_pkg::data_t   a,
    input  core_pkg::data_t   b,
    output core_pkg::data_t   y,
    output logic              carry,
    output logic              overflow
);

    localparam int MSB = `CORE_DATA_W - 1;

    logic [`CORE_DATA_W:0] sum;
    logic [3:0]            shamt;
    core_pkg::opcode_t     base_op;

    assign shamt   = b[3:0];
    assign base_op = {1'b0, opcode[`OPC_IMM_BIT-1:0]};

    always_comb begin
        sum      = '0;
        y        = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (base_op)
            `OPC_MOV: y = b;
            `OPC_ADD: begin
                sum      = {1'b0, a} + {1'b0, b};
                y        = sum[MSB:0];
                carry    = sum[`CORE_DATA_W];
                overflow = (a[MSB] == b[MSB]) && (y[MSB] != a[MSB]);
            end
            // Compare is a subtract whose result is only used for flags
            `OPC_SUB, `OPC_CMP: begin
                sum      = {1'b0, a} + {1'b0, ~b} + 1'b1;
                y        = sum[MSB:0];
                carry    = sum[`CORE_DATA_W];
                overflow = (a[MSB] != b[MSB]) && (y[MSB] != a[MSB]);
            end
            `OPC_AND: y = a & b;
            `OPC_OR:  y = a | b;
            `OPC_XOR: y = a ^ b;
            `OPC_NOT: y = ~a;
            `OPC_SL:  y = a << shamt;
            `OPC_SR: begin
                if (arith_shift) begin
                    y = $signed(a) >>> shamt;
                end else begin
                    y = a >> shamt;
                end
            end
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
// No forwarding so operands come straight from decode and halt stays set until reset
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  core_pkg::decoded_t     dec,
    output logic                   wr_en,
    output core_pkg::reg_idx_t     wr_addr,
    output core_pkg::data_t        wr_data,
    output core_pkg::exec_result_t result,
    output logic                   halted
);

    core_pkg::opcode_t      base_op;
    core_pkg::data_t        operand_b;
    core_pkg::data_t        alu_y;
    logic                   alu_carry;
    logic                   alu_overflow;
    core_pkg::flags_t       flags_q;
    core_pkg::flags_t       alu_flags;
    logic                   n_xor_v;
    logic                   cond_met;
    core_pkg::exec_result_t next;

    assign base_op   = {1'b0, dec.opcode[`OPC_IMM_BIT-1:0]};
    assign operand_b = dec.imm_en ? dec.imm : dec.rs_data;

    // The flag register lives in the output register
    assign flags_q = result.flags;

    alu alu_i (
        .opcode      (dec.opcode),
        .arith_shift (dec.cond[`SR_ARITH_BIT]),
        .a           (dec.rd_data),
        .b           (operand_b),
        .y           (alu_y),
        .carry       (alu_carry),
        .overflow    (alu_overflow)
    );

    always_comb begin
        alu_flags          = '0;
        alu_flags[`FLAG_Z] = (alu_y == '0);
        alu_flags[`FLAG_C] = alu_carry;
        alu_flags[`FLAG_N] = alu_y[`CORE_DATA_W-1];
        alu_flags[`FLAG_V] = alu_overflow;
    end

    assign n_xor_v = flags_q[`FLAG_N] ^ flags_q[`FLAG_V];

    always_comb begin
        case (dec.cond)
            `BCC_AL: cond_met = 1'b1;
            `BCC_EQ: cond_met = flags_q[`FLAG_Z];
            `BCC_NE: cond_met = !flags_q[`FLAG_Z];
            `BCC_LT: cond_met = n_xor_v;
            `BCC_GT: cond_met = !flags_q[`FLAG_Z] && !n_xor_v;
            `BCC_LE: cond_met = flags_q[`FLAG_Z] || n_xor_v;
            `BCC_GE: cond_met = !n_xor_v;
            default: cond_met = 1'b0;
        endcase
    end

    always_comb begin
        next       = '0;
        next.flags = flags_q;
        if (dec.valid) begin
            case (base_op)
                `OPC_MOV: begin
                    next.wb_valid = 1'b1;
                    next.wb_reg   = dec.rd;
                    next.wb_data  = alu_y;
                end
                `OPC_ADD, `OPC_SUB, `OPC_AND, `OPC_OR,
                `OPC_XOR, `OPC_NOT, `OPC_SL, `OPC_SR: begin
                    next.wb_valid = 1'b1;
                    next.wb_reg   = dec.rd;
                    next.wb_data  = alu_y;
                    next.flags    = alu_flags;
                end
                `OPC_CMP: next.flags = alu_flags;
                `OPC_BR: begin
                    next.branch_taken = cond_met;
                    // Immediate form is PC-relative
                    if (dec.imm_en) begin
                        next.branch_target = dec.pc + dec.imm;
                    end else begin
                        next.branch_target = dec.rd_data;
                    end
                end
                `OPC_BRL: begin
                    next.branch_taken  = cond_met;
                    next.branch_target = dec.rd_data;
                    // Link only when the branch is taken
                    next.wb_valid      = cond_met;
                    next.wb_reg        = `CORE_LINK_REG;
                    next.wb_data       = dec.pc + 1'b1;
                end
                `OPC_ST: begin
                    next.store_valid = 1'b1;
                    next.store_addr  = dec.rd_data;
                    next.store_data  = operand_b;
                end
                default: ;
            endcase
        end
    end

    // Register file write lands on the same edge as the output register
    assign wr_en   = next.wb_valid;
    assign wr_addr = next.wb_reg;
    assign wr_data = next.wb_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (dec.valid && (base_op == `OPC_HLT)) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_core.sv
// Results appear two edges after issue and a register result needs a two-cycle gap before use
`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  core_pkg::instr_t       instr,
    output core_pkg::exec_result_t result,
    output core_pkg::addr_t        pc,
    output logic                   halted
);

    core_pkg::decoded_t dec;
    core_pkg::reg_idx_t rs_idx;
    core_pkg::reg_idx_t rd_idx;
    core_pkg::data_t    rs_data;
    core_pkg::data_t    rd_data;
    logic               wr_en;
    core_pkg::reg_idx_t wr_addr;
    core_pkg::data_t    wr_data;

    issue_decode issue_decode_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .halted        (halted),
        .branch_taken  (result.branch_taken),
        .branch_target (result.branch_target),
        .rs_idx        (rs_idx),
        .rd_idx        (rd_idx),
        .rs_data       (rs_data),
        .rd_data       (rd_data),
        .dec           (dec),
        .pc            (pc)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rs_idx),
        .rd_addr_b (rd_idx),
        .rd_data_a (rs_data),
        .rd_data_b (rd_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    execute_stage execute_stage_i (
        .clk     (clk),
        .rst     (rst),
        .dec     (dec),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .result  (result),
        .halted  (halted)
    );

endmodule

`default_nettype wire

//--- verif/exec_core_checker.sv
// Sees only the top-level ports of exec_core and needs --assert in Verilator to be active
`timescale 1ns/100ps
`default_nettype none

module exec_core_checker (
    input logic                   clk,
    input logic                   rst,
    input core_pkg::exec_result_t result,
    input logic                   halted
);

    // Output register and halt come out of reset cleared
    reset_clear: assert property (@(posedge clk) $fell(rst) |->
            !result.wb_valid && !result.store_valid && !result.branch_taken && !halted)
        else $error("A strobe or halted was set in the first cycle after reset");

    // Halt is sticky until the next reset
    halt_sticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
        else $error("halted fell while rst was low");

    store_or_wb: assert property (@(posedge clk) disable iff (rst)
            !(result.store_valid && result.wb_valid))
        else $error("store_valid and wb_valid were high in the same cycle");

endmodule

bind exec_core exec_core_checker exec_core_checker_i (
    .clk    (clk),
    .rst    (rst),
    .result (result),
    .halted (halted)
);

`default_nettype wire

//--- verif/exec_core_tb.sv
// Run from the project root since verif/core_tests.txt is opened by a relative path
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int LINE_CYCLES  = 40;
    localparam int MAX_TESTS    = 64;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    core_pkg::instr_t       instr;
    core_pkg::exec_result_t result;
    core_pkg::addr_t        pc;
    logic                   halted;

    // One entry per line of the test file
    core_pkg::instr_t       test_instr [MAX_TESTS];
    int                     test_gap [MAX_TESTS];
    core_pkg::exec_result_t exp_result [MAX_TESTS];
    logic                   exp_halted [MAX_TESTS];
    core_pkg::addr_t        exp_pc [MAX_TESTS];
    int                     n_tests;
    int                     n_checks;
    int                     n_errors;
    logic                   loaded;

    exec_core exec_core_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result),
        .pc          (pc),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic load_tests();
        int          fd;
        int          n_fields;
        string       line;
        logic [23:0] word;
        int          gap;
        logic [11:0] f [11];
        fd = $fopen("verif/core_tests.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Could not open verif/core_tests.txt");
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Skip comment and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %d %h %h %h %h %h %h %h %h %h %h %h", word, gap,
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n_fields != 13) begin
                n_errors++;
                $display("Test line %0d has %0d fields instead of 13", n_tests, n_fields);
                continue;
            end
            test_instr[n_tests]               = word;
            test_gap[n_tests]                 = gap;
            exp_result[n_tests]               = '0;
            exp_result[n_tests].wb_valid      = f[0][0];
            exp_result[n_tests].wb_reg        = f[1][3:0];
            exp_result[n_tests].wb_data       = f[2];
            exp_result[n_tests].flags         = f[3][3:0];
            exp_result[n_tests].branch_taken  = f[4][0];
            exp_result[n_tests].branch_target = f[5];
            exp_result[n_tests].store_valid   = f[6][0];
            exp_result[n_tests].store_addr    = f[7];
            exp_result[n_tests].store_data    = f[8];
            exp_halted[n_tests]               = f[9][0];
            exp_pc[n_tests]                   = f[10];
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0) begin
            n_errors++;
            $display("No test lines were read from verif/core_tests.txt");
        end
    endtask

    task automatic compare_field(int idx, string name, logic [23:0] actual,
                                 logic [23:0] expected);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("Mismatch at %0d ns: %s expected %h got %h (test line %0d)",
                     $time, name, expected, actual, idx);
        end
    endtask

    task automatic run_line(int idx);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= test_instr[idx];
        // Edge E takes the word into the decode register
        @(posedge clk);
        instr_valid <= 1'b0;
        // Edge E+1 loads the execute output register
        @(posedge clk);
        @(negedge clk);
        compare_field(idx, "wb_valid", result.wb_valid, exp_result[idx].wb_valid);
        compare_field(idx, "wb_reg", result.wb_reg, exp_result[idx].wb_reg);
        compare_field(idx, "wb_data", result.wb_data, exp_result[idx].wb_data);
        compare_field(idx, "flags", result.flags, exp_result[idx].flags);
        compare_field(idx, "branch_taken", result.branch_taken, exp_result[idx].branch_taken);
        compare_field(idx, "branch_target", result.branch_target,
                      exp_result[idx].branch_target);
        compare_field(idx, "store_valid", result.store_valid, exp_result[idx].store_valid);
        compare_field(idx, "store_addr", result.store_addr, exp_result[idx].store_addr);
        compare_field(idx, "store_data", result.store_data, exp_result[idx].store_data);
        compare_field(idx, "halted", halted, exp_halted[idx]);
        // A taken branch reloads pc one edge later
        @(posedge clk);
        @(negedge clk);
        compare_field(idx, "pc", pc, exp_pc[idx]);
        repeat (test_gap[idx]) @(posedge clk);
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        loaded      = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_line(i);
        end
        @(posedge clk);
        $display("Summary: %0d test lines, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of test lines
    initial begin
        wait (loaded);
        #((n_tests * LINE_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 n_tests * LINE_CYCLES + RESET_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/core_tests.txt
# instr gap wb_valid wb_reg wb_data flags br_taken br_target st_valid st_addr st_data halted pc
# All hex except gap (decimal idle cycles), flags are {V,N,C,Z}, pc is sampled after the branch edge
8017FF 0 1 1 7FF 0 0 000 0 000 000 0 001
802001 1 1 2 001 0 0 000 0 000 000 0 002
081200 0 1 1 800 C 0 000 0 000 000 0 003
803FFF 0 1 3 FFF C 0 000 0 000 000 0 004
083200 2 1 3 000 3 0 000 0 000 000 0 005
101200 0 1 1 7FF A 0 000 0 000 000 0 006
804A5C 0 1 4 A5C A 0 000 0 000 000 0 007
201400 0 1 1 25C 0 0 000 0 000 000 0 008
284200 1 1 4 A5D 4 0 000 0 000 000 0 009
304100 0 1 4 801 4 0 000 0 000 000 0 00A
382000 0 1 2 FFE 4 0 000 0 000 000 0 00B
C94002 0 1 4 E00 4 0 000 0 000 000 0 00C
805003 0 1 5 003 4 0 000 0 000 000 0 00D
484500 0 1 4 1C0 0 0 000 0 000 000 0 00E
404500 3 1 4 E00 4 0 000 0 000 000 0 00F
985003 0 0 0 000 3 0 000 0 000 000 0 010
D10005 0 0 0 000 3 1 015 0 000 000 0 015
D20FFE 0 0 0 000 3 0 013 0 000 000 0 016
531000 0 0 0 000 3 0 25C 0 000 000 0 017
561000 1 0 0 000 3 1 25C 0 000 000 0 25C
D50010 0 0 0 000 3 1 26C 0 000 000 0 26C
D40004 0 0 0 000 3 0 270 0 000 000 0 26D
182500 0 0 0 000 6 0 000 0 000 000 0 26E
531000 0 0 0 000 6 1 25C 0 000 000 0 25C
561000 0 0 0 000 6 0 25C 0 000 000 0 25D
D20003 2 0 0 000 6 1 260 0 000 000 0 260
514000 0 0 0 000 6 0 E00 0 000 000 0 261
185200 0 0 0 000 0 0 000 0 000 000 0 262
544000 0 0 0 000 0 1 E00 0 000 000 0 E00
D50007 0 0 0 000 0 0 E07 0 000 000 0 E01
581000 1 1 F E02 0 1 25C 0 000 000 0 25C
604F00 0 0 0 000 0 0 000 1 E00 E02 0 25D
E015A5 0 0 0 000 0 0 000 1 25C 5A5 0 25E
680000 0 0 0 000 0 0 000 0 000 000 1 25F
806123 0 0 0 000 0 0 000 0 000 000 1 25F
E01111 0 0 0 000 0 0 000 0 000 000 1 25F

//--- verilog.f
+incdir+common
common/core_pkg.sv
src/reg_file.sv
src/issue_decode.sv
execute/alu.sv
execute/execute_stage.sv
src/exec_core.sv
verif/exec_core_checker.sv
verif/exec_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds exec_core_tb with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module exec_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vexec_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0
